/* source/fetch_pkg.sv */
package fetch_pkg;

    localparam int VADDR_W    = 32;
    localparam int BLOCK_INST = 8;   // Instructions per cache block.
    localparam int INST_W     = 32;
    localparam int LANE_W     = 3;
    localparam int SIZE_W     = 3;   // Instruction count minus one.
    localparam int FSQ_IDX_W  = 4;
    localparam int BLOCK_W    = BLOCK_INST * INST_W;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Lanes from start up to start + size, cut off at the end of the block.
    function automatic logic [BLOCK_INST-1:0] lane_mask(
        input logic [LANE_W-1:0] start,
        input logic [SIZE_W-1:0] size
    );
        logic [BLOCK_INST-1:0] mask;
        int first;
        int last;
        first = int'(start);
        last  = first + int'(size);
        for (int i = 0; i < BLOCK_INST; i++) begin
            mask[i] = (i >= first) && (i <= last);
        end
        return mask;
    endfunction

endpackage

/* source/icache_ctrl.sv */
module icache_ctrl import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_req,
    input  logic [VADDR_W-1:0]    fetch_addr,
    input  logic [SIZE_W-1:0]     fetch_size,
    input  logic [FSQ_IDX_W-1:0]  fetch_idx,
    output logic                  fetch_ready,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  abandon,
    input  logic [FSQ_IDX_W-1:0]  abandon_idx,
    input  logic [VADDR_W-1:0]    abandon_addr,
    input  logic [SIZE_W-1:0]     abandon_size,
    output logic                  abandon_hit,
    input  logic                  cache_ready,
    input  logic                  state_idle,
    input  logic                  state_lookup,
    input  logic                  data_valid,
    input  logic [BLOCK_W-1:0]    block_data,
    output logic                  lookup_req,
    output logic [VADDR_W-1:0]    lookup_addr,
    output logic                  pd_valid,
    output logic [BLOCK_INST-1:0] pd_mask,
    output logic [BLOCK_W-1:0]    pd_data,
    output logic [VADDR_W-1:0]    pd_addr,
    output logic [FSQ_IDX_W-1:0]  pd_idx
);

    logic                  abandon_idle;
    logic                  abandon_lookup;
    logic                  accept;
    logic [VADDR_W-1:0]    sel_addr;
    logic [SIZE_W-1:0]     sel_size;
    logic [BLOCK_INST-1:0] sel_mask;
    logic [BLOCK_INST-1:0] abandon_mask;
    logic [BLOCK_INST-1:0] en_s2;
    logic [BLOCK_INST-1:0] mask_s2;
    logic [VADDR_W-1:0]    addr_s2;
    logic [FSQ_IDX_W-1:0]  idx_s2;

    // Abandon aimed at the stream offered this cycle, or at the one held in stage 2.
    assign abandon_idle   = abandon & state_idle & (abandon_idx == fetch_idx);
    assign abandon_lookup = abandon & state_lookup & (abandon_idx == idx_s2);

    assign fetch_ready = cache_ready;
    assign lookup_req  = fetch_req & ~stall;
    assign accept      = lookup_req & cache_ready;
    assign abandon_hit = accept & abandon_idle;

    assign sel_addr    = abandon_idle ? abandon_addr : fetch_addr;
    assign sel_size    = abandon_idle ? abandon_size : fetch_size;
    assign lookup_addr = sel_addr; // The cache looks up the stream that is kept.

    assign sel_mask     = lane_mask(sel_addr[LANE_W+1:2], sel_size);
    assign abandon_mask = lane_mask(abandon_addr[LANE_W+1:2], abandon_size);

    always_ff @(posedge clk) begin
        if (abandon_lookup) begin
            addr_s2 <= abandon_addr;
        end else if (accept) begin
            addr_s2 <= sel_addr;
            idx_s2  <= fetch_idx;
        end
    end

    // Stage-2 lane enables; an empty mask means nothing is waiting.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_s2 <= '0;
        end else if (flush) begin
            en_s2 <= '0;
        end else if (data_valid) begin
            en_s2 <= '0;
        end else if (abandon_lookup) begin
            en_s2 <= abandon_mask;
        end else if (accept) begin
            en_s2 <= sel_mask;
        end
    end

    // An abandon in the cycle the data comes back still takes effect.
    assign mask_s2 = abandon_lookup ? abandon_mask : en_s2;
    assign pd_mask = mask_s2 & {BLOCK_INST{data_valid}};
    assign pd_valid = |pd_mask;
    assign pd_addr  = abandon_lookup ? abandon_addr : addr_s2;
    assign pd_idx   = idx_s2;
    assign pd_data  = block_data;

    a_accept_when_idle: assert property (
        @(posedge clk) disable iff (!rst) accept |-> state_idle
    );

    // Data only comes back for a stream that was accepted earlier.
    a_data_needs_request: assert property (
        @(posedge clk) disable iff (!rst) data_valid |-> (en_s2 != '0)
    );

endmodule

/* source/icache_array.sv */
module icache_array import fetch_pkg::*; #(
    parameter int NUM_SETS = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               lookup_req,
    input  logic [VADDR_W-1:0] lookup_addr,
    input  logic               flush,
    output logic               cache_ready,
    output logic               state_idle,
    output logic               state_lookup,
    output logic               data_valid,
    output logic [BLOCK_W-1:0] block_data,
    output logic               mem_req,
    output logic [VADDR_W-1:0] mem_addr,
    input  logic               mem_rsp_valid,
    input  logic [BLOCK_W-1:0] mem_rsp_data
);

    localparam int OFF_W = LANE_W + 2;           // Byte offset inside a block.
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int BLK_W = VADDR_W - OFF_W;
    localparam int TAG_W = BLK_W - IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_REFILL,
        S_RESP
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [TAG_W-1:0]   tag_mem [NUM_SETS];
    logic [BLOCK_W-1:0] data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    logic [BLK_W-1:0]   blk_q;     // Block address of the current request.
    logic [TAG_W-1:0]   rd_tag_q;
    logic               rd_valid_q;
    logic [BLOCK_W-1:0] rd_data_q;
    logic               flushed_q;

    logic [IDX_W-1:0]   lookup_idx;
    logic [IDX_W-1:0]   req_idx;
    logic [TAG_W-1:0]   req_tag;
    logic               start;
    logic               hit;
    logic               refill_done;

    assign lookup_idx  = lookup_addr[OFF_W +: IDX_W];
    assign req_idx     = blk_q[IDX_W-1:0];
    assign req_tag     = blk_q[IDX_W +: TAG_W];
    assign start       = lookup_req & (state_q == S_IDLE);
    assign hit         = rd_valid_q & (rd_tag_q == req_tag);
    assign refill_done = (state_q == S_REFILL) & mem_rsp_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (lookup_req) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_d = hit ? S_IDLE : S_REFILL;
            end
            S_REFILL: begin
                if (mem_rsp_valid) begin
                    state_d = S_RESP;
                end
            end
            default: begin
                state_d = S_IDLE; // S_RESP lasts one cycle.
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= S_IDLE;
            valid_q   <= '0;
            flushed_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (refill_done) begin
                valid_q[req_idx] <= 1'b1;
            end
            // A flushed request still refills but returns nothing.
            if (start) begin
                flushed_q <= flush;
            end else if (flush) begin
                flushed_q <= 1'b1;
            end
        end
    end

    // Arrays are read when the request is taken, so the compare runs in S_LOOKUP.
    always_ff @(posedge clk) begin
        if (start) begin
            blk_q      <= lookup_addr[VADDR_W-1:OFF_W];
            rd_tag_q   <= tag_mem[lookup_idx];
            rd_valid_q <= valid_q[lookup_idx];
            rd_data_q  <= data_mem[lookup_idx];
        end else if (refill_done) begin
            rd_data_q <= mem_rsp_data;
        end
        if (refill_done) begin
            tag_mem[req_idx]  <= req_tag;
            data_mem[req_idx] <= mem_rsp_data;
        end
    end

    assign cache_ready  = (state_q == S_IDLE);
    assign state_idle   = (state_q == S_IDLE);
    assign state_lookup = (state_q == S_LOOKUP) | (state_q == S_REFILL);

    assign data_valid = ~flushed_q & ~flush &
                        (((state_q == S_LOOKUP) & hit) | (state_q == S_RESP));
    assign block_data = rd_data_q;

    assign mem_req  = (state_q == S_LOOKUP) & ~hit;
    assign mem_addr = {blk_q, {OFF_W{1'b0}}};

    a_mem_req_pulse: assert property (
        @(posedge clk) disable iff (!rst) mem_req |=> !mem_req
    );

    // Only one miss is outstanding, so a response without a refill is stray.
    a_rsp_in_refill: assert property (
        @(posedge clk) disable iff (!rst) mem_rsp_valid |-> (state_q == S_REFILL)
    );

endmodule

/* source/predecode.sv */
module predecode import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pd_valid,
    input  logic [BLOCK_INST-1:0] pd_mask,
    input  logic [BLOCK_W-1:0]    pd_data,
    input  logic [VADDR_W-1:0]    pd_addr,
    input  logic [FSQ_IDX_W-1:0]  pd_idx,
    output logic                  out_valid,
    output logic [BLOCK_INST-1:0] out_mask,
    output logic [BLOCK_INST-1:0] out_branch,
    output logic [BLOCK_INST-1:0] out_jal,
    output logic [VADDR_W-1:0]    out_addr,
    output logic [FSQ_IDX_W-1:0]  out_idx,
    output logic [BLOCK_W-1:0]    out_data
);

    logic [BLOCK_INST-1:0] branch_d;
    logic [BLOCK_INST-1:0] jal_d;

    // Lane i holds the word at block base plus 4*i.
    always_comb begin
        for (int i = 0; i < BLOCK_INST; i++) begin
            branch_d[i] = pd_mask[i] && (pd_data[i*INST_W +: 7] == OPC_BRANCH);
            jal_d[i]    = pd_mask[i] && (pd_data[i*INST_W +: 7] == OPC_JAL);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            out_mask   <= '0;
            out_branch <= '0;
            out_jal    <= '0;
        end else begin
            out_valid <= pd_valid;
            if (pd_valid) begin
                out_mask   <= pd_mask;
                out_branch <= branch_d;
                out_jal    <= jal_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pd_valid) begin
            out_addr <= pd_addr;
            out_idx  <= pd_idx;
            out_data <= pd_data;
        end
    end

    // Every presented block has at least one enabled lane.
    a_out_has_lane: assert property (
        @(posedge clk) disable iff (!rst) out_valid |-> (out_mask != '0)
    );

endmodule

/* source/fetch_frontend.sv */
module fetch_frontend import fetch_pkg::*; #(
    parameter int NUM_SETS = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_req,
    input  logic [VADDR_W-1:0]    fetch_addr,
    input  logic [SIZE_W-1:0]     fetch_size,
    input  logic [FSQ_IDX_W-1:0]  fetch_idx,
    output logic                  fetch_ready,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  abandon,
    input  logic [FSQ_IDX_W-1:0]  abandon_idx,
    input  logic [VADDR_W-1:0]    abandon_addr,
    input  logic [SIZE_W-1:0]     abandon_size,
    output logic                  abandon_hit,
    output logic                  mem_req,
    output logic [VADDR_W-1:0]    mem_addr,
    input  logic                  mem_rsp_valid,
    input  logic [BLOCK_W-1:0]    mem_rsp_data,
    output logic                  out_valid,
    output logic [BLOCK_INST-1:0] out_mask,
    output logic [BLOCK_INST-1:0] out_branch,
    output logic [BLOCK_INST-1:0] out_jal,
    output logic [VADDR_W-1:0]    out_addr,
    output logic [FSQ_IDX_W-1:0]  out_idx,
    output logic [BLOCK_W-1:0]    out_data
);

    logic                  lookup_req;
    logic [VADDR_W-1:0]    lookup_addr;
    logic                  cache_ready;
    logic                  state_idle;
    logic                  state_lookup;
    logic                  data_valid;
    logic [BLOCK_W-1:0]    block_data;
    logic                  pd_valid;
    logic [BLOCK_INST-1:0] pd_mask;
    logic [BLOCK_W-1:0]    pd_data;
    logic [VADDR_W-1:0]    pd_addr;
    logic [FSQ_IDX_W-1:0]  pd_idx;

    icache_ctrl ctrl_i (
        .clk, .rst,
        .fetch_req, .fetch_addr, .fetch_size, .fetch_idx, .fetch_ready,
        .stall, .flush,
        .abandon, .abandon_idx, .abandon_addr, .abandon_size, .abandon_hit,
        .cache_ready, .state_idle, .state_lookup, .data_valid, .block_data,
        .lookup_req, .lookup_addr,
        .pd_valid, .pd_mask, .pd_data, .pd_addr, .pd_idx
    );

    icache_array #(.NUM_SETS(NUM_SETS)) array_i (
        .clk, .rst,
        .lookup_req, .lookup_addr, .flush,
        .cache_ready, .state_idle, .state_lookup, .data_valid, .block_data,
        .mem_req, .mem_addr, .mem_rsp_valid, .mem_rsp_data
    );

    predecode predecode_i (
        .clk, .rst,
        .pd_valid, .pd_mask, .pd_data, .pd_addr, .pd_idx,
        .out_valid, .out_mask, .out_branch, .out_jal, .out_addr, .out_idx, .out_data
    );

endmodule

/* sim/tb_mem_model.sv */
module tb_mem_model import fetch_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req,
    input  logic [VADDR_W-1:0] mem_addr,
    output logic               mem_rsp_valid,
    output logic [BLOCK_W-1:0] mem_rsp_data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]        rng;
    logic [31:0]        rng_next;
    logic [3:0]         wait_cnt;
    logic               busy;
    logic [VADDR_W-1:0] addr_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word contents are a hash of the word address; the opcode cycles with index mod 3.
    function automatic logic [31:0] word_at(input logic [VADDR_W-1:0] a);
        logic [31:0] widx;
        logic [31:0] h;
        logic [6:0]  opc;
        widx = {2'b00, a[31:2]};
        h    = widx * 32'h9E37_79B1;
        h    = h ^ (h >> 15);
        if (widx % 3 == 0) begin
            opc = OPC_BRANCH;
        end else if (widx % 3 == 1) begin
            opc = OPC_JAL;
        end else begin
            opc = 7'b0010011; // OP-IMM.
        end
        return {h[31:7], opc};
    endfunction

    function automatic logic [BLOCK_W-1:0] block_at(input logic [VADDR_W-1:0] a);
        logic [BLOCK_W-1:0] blk;
        logic [2:0]         lane;
        for (int i = 0; i < BLOCK_INST; i++) begin
            lane = 3'(i);
            blk[i*INST_W +: INST_W] = word_at({a[31:5], lane, 2'b00});
        end
        return blk;
    endfunction

    assign rng_next = xorshift(rng);

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            rng           <= 32'd10;
            busy          <= 1'b0;
            wait_cnt      <= 4'd0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
            addr_q        <= '0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (mem_req) begin
                rng      <= rng_next;
                wait_cnt <= 4'd2 + {1'b0, rng_next[2:0]}; // 2 to 9 cycles.
                busy     <= 1'b1;
                addr_q   <= mem_addr;
            end else if (busy) begin
                if (wait_cnt == 4'd1) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= block_at(addr_q);
                    busy          <= 1'b0;
                end
                wait_cnt <= wait_cnt - 4'd1;
            end
        end
    end

endmodule

/* sim/tb_fetch_frontend.sv */
module tb_fetch_frontend import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SETS   = 16;
    localparam int MAX_CYCLES = 4000; // About 30 streams of at most 15 cycles, with margin.

    logic                  clk;
    logic                  rst;
    logic                  fetch_req;
    logic [VADDR_W-1:0]    fetch_addr;
    logic [SIZE_W-1:0]     fetch_size;
    logic [FSQ_IDX_W-1:0]  fetch_idx;
    logic                  fetch_ready;
    logic                  stall;
    logic                  flush;
    logic                  abandon;
    logic [FSQ_IDX_W-1:0]  abandon_idx;
    logic [VADDR_W-1:0]    abandon_addr;
    logic [SIZE_W-1:0]     abandon_size;
    logic                  abandon_hit;
    logic                  mem_req;
    logic [VADDR_W-1:0]    mem_addr;
    logic                  mem_rsp_valid;
    logic [BLOCK_W-1:0]    mem_rsp_data;
    logic                  out_valid;
    logic [BLOCK_INST-1:0] out_mask;
    logic [BLOCK_INST-1:0] out_branch;
    logic [BLOCK_INST-1:0] out_jal;
    logic [VADDR_W-1:0]    out_addr;
    logic [FSQ_IDX_W-1:0]  out_idx;
    logic [BLOCK_W-1:0]    out_data;

    // Reference state of the one stream in flight.
    int                   cyc = 0;
    logic                 pend;
    logic [VADDR_W-1:0]   exp_addr;
    logic [SIZE_W-1:0]    exp_size;
    logic [FSQ_IDX_W-1:0] exp_idx;
    logic [26:0]          exp_blk;
    logic                 exp_hit;
    logic                 exp_flushed;
    logic                 exp_rsp;
    logic                 req_seen;
    int                   exp_cyc;
    logic [NUM_SETS-1:0]  res_valid;
    logic [26:0]          res_blk [NUM_SETS];
    logic                 accept;
    logic                 ab_idle;
    logic [31:0]          rnd;

    fetch_frontend #(.NUM_SETS(NUM_SETS)) dut_i (.*);

    tb_mem_model mem_i (.clk, .rst, .mem_req, .mem_addr, .mem_rsp_valid, .mem_rsp_data);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] ref_word(input logic [VADDR_W-1:0] a);
        logic [31:0] widx;
        logic [31:0] h;
        logic [6:0]  opc;
        widx = {2'b00, a[31:2]};
        h    = widx * 32'h9E37_79B1;
        h    = h ^ (h >> 15);
        opc  = (widx % 3 == 0) ? 7'b1100011 : (widx % 3 == 1) ? 7'b1101111 : 7'b0010011;
        return {h[31:7], opc};
    endfunction

    function automatic logic [BLOCK_W-1:0] ref_block(input logic [VADDR_W-1:0] a);
        logic [BLOCK_W-1:0] blk;
        logic [2:0]         lane;
        for (int i = 0; i < BLOCK_INST; i++) begin
            lane = 3'(i);
            blk[i*INST_W +: INST_W] = ref_word({a[31:5], lane, 2'b00});
        end
        return blk;
    endfunction

    function automatic logic [BLOCK_INST-1:0] ref_mask(input logic [VADDR_W-1:0] a,
                                                      input logic [SIZE_W-1:0] size);
        logic [BLOCK_INST-1:0] m;
        for (int i = 0; i < BLOCK_INST; i++) begin
            m[i] = (i >= int'(a[4:2])) && (i <= int'(a[4:2]) + int'(size));
        end
        return m;
    endfunction

    // Word index mod 3 picks the class. 0 is a branch and 1 a JAL.
    function automatic logic [BLOCK_INST-1:0] ref_class(input logic [VADDR_W-1:0] a,
                                                       input logic [SIZE_W-1:0] size,
                                                       input int rem);
        logic [BLOCK_INST-1:0] m;
        logic [BLOCK_INST-1:0] c;
        logic [31:0]           widx;
        m = ref_mask(a, size);
        for (int i = 0; i < BLOCK_INST; i++) begin
            widx = {2'b0, a[31:5], 3'(i)};
            c[i] = m[i] && (int'(widx % 3) == rem);
        end
        return c;
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "check failed");
    endtask

    assign accept  = fetch_req && fetch_ready && !stall;
    assign ab_idle = abandon && (abandon_idx == fetch_idx);

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            pend        <= 1'b0;
            exp_flushed <= 1'b0;
            exp_rsp     <= 1'b0;
            req_seen    <= 1'b0;
            exp_hit     <= 1'b0;
            res_valid   <= '0;
        end else if (accept) begin
            pend        <= 1'b1;
            exp_addr    <= ab_idle ? abandon_addr : fetch_addr;
            exp_size    <= ab_idle ? abandon_size : fetch_size;
            exp_idx     <= fetch_idx;
            exp_blk     <= ab_idle ? abandon_addr[31:5] : fetch_addr[31:5];
            exp_hit     <= ab_idle
                ? res_valid[abandon_addr[8:5]] && res_blk[abandon_addr[8:5]] == abandon_addr[31:5]
                : res_valid[fetch_addr[8:5]] && res_blk[fetch_addr[8:5]] == fetch_addr[31:5];
            exp_cyc     <= cyc;
            exp_flushed <= flush;
            exp_rsp     <= 1'b0;
            req_seen    <= 1'b0;
        end else if (pend) begin
            if (abandon && abandon_idx == exp_idx) begin
                exp_addr <= abandon_addr;
                exp_size <= abandon_size;
            end
            if (flush) begin
                exp_flushed <= 1'b1;
            end
            if (mem_req) begin
                req_seen <= 1'b1;
            end
            if (mem_rsp_valid) begin
                exp_rsp                 <= 1'b1;
                res_valid[exp_blk[3:0]] <= 1'b1;
                res_blk[exp_blk[3:0]]   <= exp_blk;
                if (exp_flushed || flush) begin
                    pend <= 1'b0; // Flushed refill fills the array but returns nothing.
                end
            end
            if (out_valid) begin
                pend <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    a_out_expected: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> pend && !exp_flushed)
        else report_fail("out_valid without an expected stream");
    a_out_tag: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> out_addr == exp_addr && out_idx == exp_idx)
        else report_fail("wrong out_addr or out_idx");
    a_out_mask: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> out_mask == ref_mask(exp_addr, exp_size))
        else report_fail("wrong out_mask");
    a_out_data: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> out_data == ref_block(exp_addr))
        else report_fail("wrong out_data");
    a_predecode: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> out_branch == ref_class(exp_addr, exp_size, 0)
                      && out_jal == ref_class(exp_addr, exp_size, 1))
        else report_fail("wrong out_branch or out_jal");
    a_hit_late: assert property (@(posedge clk) disable iff (!rst)
        (pend && exp_hit && cyc == exp_cyc + 2) |-> out_valid)
        else report_fail("hit output missing two cycles after acceptance");
    a_hit_early: assert property (@(posedge clk) disable iff (!rst)
        (out_valid && exp_hit) |-> cyc == exp_cyc + 2)
        else report_fail("hit output not two cycles after acceptance");
    a_miss_ready: assert property (@(posedge clk) disable iff (!rst)
        (pend && !exp_hit && !exp_rsp) |-> !fetch_ready)
        else report_fail("fetch_ready high during a miss");
    a_mem_req: assert property (@(posedge clk) disable iff (!rst)
        mem_req |-> pend && !exp_hit && !req_seen && mem_addr == {exp_blk, 5'b0})
        else report_fail("unexpected or wrong memory request");
    a_abandon_set: assert property (@(posedge clk) disable iff (!rst)
        (accept && ab_idle) |-> abandon_hit)
        else report_fail("abandon_hit missing on abandon at idle");
    a_abandon_only: assert property (@(posedge clk) disable iff (!rst)
        abandon_hit |-> accept && ab_idle)
        else report_fail("abandon_hit without a matching abandon");

    task automatic do_fetch(input logic [VADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                            input logic [FSQ_IDX_W-1:0] idx, input logic ab,
                            input logic [FSQ_IDX_W-1:0] ab_idx,
                            input logic [VADDR_W-1:0] ab_addr, input int stall_left);
        logic done;
        done = 1'b0;
        @(posedge clk);
        fetch_req    <= 1'b1;
        fetch_addr   <= addr;
        fetch_size   <= size;
        fetch_idx    <= idx;
        abandon      <= ab;
        abandon_idx  <= ab_idx;
        abandon_addr <= ab_addr;
        abandon_size <= 3'd1;
        stall        <= (stall_left > 0);
        while (!done) begin
            @(posedge clk);
            if (fetch_ready && !stall) begin
                done = 1'b1;
            end else begin
                if (stall_left > 0) stall_left--;
                stall <= (stall_left > 0);
            end
        end
        fetch_req <= 1'b0;
        abandon   <= 1'b0;
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (pend) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // Pulses abandon or flush for one cycle while the refill is outstanding.
    task automatic during_refill(input logic do_flush, input logic [FSQ_IDX_W-1:0] idx,
                                 input logic [VADDR_W-1:0] addr, input logic [SIZE_W-1:0] size);
        @(posedge clk);
        while (!mem_req) @(posedge clk);
        if (do_flush) begin
            flush <= 1'b1;
        end else begin
            abandon      <= 1'b1;
            abandon_idx  <= idx;
            abandon_addr <= addr;
            abandon_size <= size;
        end
        @(posedge clk);
        flush   <= 1'b0;
        abandon <= 1'b0;
    endtask

    initial begin
        rst = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        fetch_size = '0;
        fetch_idx = '0;
        stall = 1'b0;
        flush = 1'b0;
        abandon = 1'b0;
        abandon_idx = '0;
        abandon_addr = '0;
        abandon_size = '0;
        rnd = 32'd10;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);

        do_fetch(32'h100, 3'd7, 4'd1, 1'b0, 4'd0, '0, 0);  // Cold miss.
        wait_done();
        do_fetch(32'h108, 3'd3, 4'd2, 1'b0, 4'd0, '0, 0);
        wait_done();
        do_fetch(32'h118, 3'd5, 4'd3, 1'b0, 4'd0, '0, 3);  // Clipped, after a stall.
        wait_done();
        do_fetch(32'h300, 3'd7, 4'd4, 1'b1, 4'd4, 32'h104, 0);
        wait_done();
        do_fetch(32'h120, 3'd2, 4'd8, 1'b1, 4'd9, 32'h100, 0); // Index differs, no abandon.
        wait_done();
        do_fetch(32'h200, 3'd7, 4'd5, 1'b0, 4'd0, '0, 0);
        during_refill(1'b0, 4'd5, 32'h20c, 3'd2);
        wait_done();
        do_fetch(32'h400, 3'd7, 4'd6, 1'b0, 4'd0, '0, 0);
        during_refill(1'b1, 4'd0, '0, 3'd0);
        wait_done();
        do_fetch(32'h404, 3'd2, 4'd7, 1'b0, 4'd0, '0, 0);  // Hits after the flushed refill.
        wait_done();
        do_fetch(32'h300, 3'd4, 4'd9, 1'b0, 4'd0, '0, 0);  // Evicts the block at 0x100.
        wait_done();
        do_fetch(32'h110, 3'd1, 4'd10, 1'b0, 4'd0, '0, 0);
        wait_done();

        for (int n = 0; n < 16; n++) begin
            rnd = next_rand(rnd);
            do_fetch(32'h1000 | {21'b0, rnd[9:8], 4'b0, rnd[4:2], 2'b00}, rnd[7:5],
                     rnd[13:10], 1'b0, 4'd0, '0, 0);
            wait_done();
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* fetch_frontend.f */
source/fetch_pkg.sv
source/icache_ctrl.sv
source/icache_array.sv
source/predecode.sv
source/fetch_frontend.sv
sim/tb_mem_model.sv
sim/tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front-end testbench with Verilator.
# The exit status is the simulator's own: zero on pass, non-zero on failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_frontend \
    -f fetch_frontend.f \
    -o tb_fetch_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_fetch_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
